// ==== hdl/lock_pkg.sv ====
package lock_pkg;

    typedef logic [3:0] key_t;                     // 0..9 are digits

    localparam key_t KEY_ENTER  = 4'd10;
    localparam key_t KEY_CANCEL = 4'd11;
    localparam key_t KEY_ADMIN  = 4'd12;
    localparam key_t KEY_NONE   = 4'd15;           // also used for unwired lines

    // display word, read either as three digit nibbles or as one glyph
    typedef union packed {
        logic [2:0][3:0] digit;                    // digit[0] is the newest
        logic [11:0]     raw;
    } display_t;

    localparam logic [11:0] GLYPH_BLANK  = 12'hFFF;
    localparam logic [11:0] GLYPH_PASS   = 12'hBCC;
    localparam logic [11:0] GLYPH_LOCKED = 12'h000;

    localparam display_t SECRET_CODE = display_t'(12'h246);
    localparam int MAX_TRIES = 4;                  // wrong codes before lockout
    localparam int TRY_W     = 3;
    localparam int CODE_LEN  = 3;

    // tone patterns, lengths in clock cycles
    localparam int CLICK_CYCLES = 2000;
    localparam int CLICK_HALF   = 50;
    localparam int PASS_CYCLES  = 6000;
    localparam int PASS_HALF    = 25;
    localparam int FAIL_CYCLES  = 3000;
    localparam int FAIL_HALF    = 100;
    localparam int FAIL_GAP_LO  = 1000;            // silent part of the fail tone
    localparam int FAIL_GAP_HI  = 2000;

    localparam int DUR_W  = $clog2(PASS_CYCLES);   // pass is the longest pattern
    localparam int HALF_W = $clog2(FAIL_HALF);     // fail has the longest half period

    localparam int PAT_W = 2;
    localparam logic [PAT_W-1:0] PAT_IDLE  = 2'd0;
    localparam logic [PAT_W-1:0] PAT_CLICK = 2'd1;
    localparam logic [PAT_W-1:0] PAT_PASS  = 2'd2;
    localparam logic [PAT_W-1:0] PAT_FAIL  = 2'd3;

    // keypad line to key code, index is the line number
    localparam key_t KEYMAP [16] = '{
        KEY_ENTER,                                 // line 0
        KEY_NONE,
        KEY_NONE,
        4'd0,
        KEY_NONE,
        4'd3,
        4'd2,
        4'd1,
        KEY_ADMIN,                                 // line 8
        4'd6,
        4'd5,
        4'd4,
        KEY_CANCEL,                                // line 12
        4'd9,
        4'd8,
        4'd7
    };

endpackage

// ==== hdl/key_decoder.sv ====
module key_decoder (
    input  logic           clk,
    input  logic           arst_n,
    input  logic [15:0]    onehot,
    output logic           key_strobe,
    output lock_pkg::key_t key_code
);

    logic [15:0]    sample_q;                      // current keypad sample
    logic [15:0]    prev_q;                        // sample one cycle older
    logic           single;
    logic           changed;
    lock_pkg::key_t code_lu;

    // exactly one line set
    assign single  = (sample_q != '0) && ((sample_q & (sample_q - 16'd1)) == '0);
    assign changed = (sample_q != prev_q);

    always_comb begin
        code_lu = lock_pkg::KEY_NONE;
        for (int i = 0; i < 16; i++) begin
            if (sample_q[i]) begin
                code_lu = lock_pkg::KEYMAP[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sample_q   <= '0;
            prev_q     <= '0;
            key_strobe <= 1'b0;
        end else begin
            sample_q   <= onehot;
            prev_q     <= sample_q;
            // held keys give no second strobe, release counts as a change
            key_strobe <= changed && single && (code_lu != lock_pkg::KEY_NONE);
        end
    end

    always_ff @(posedge clk) begin
        key_code <= code_lu;                       // only read with key_strobe
    end

endmodule

// ==== hdl/code_entry.sv ====
module code_entry (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               key_strobe,
    input  lock_pkg::key_t     key_code,
    input  logic               locked,
    input  logic               clear_entry,
    output lock_pkg::display_t entry,
    output logic [1:0]         digit_count,
    output logic               enter_req,
    output logic               cancel_req,
    output logic               admin_req,
    output logic               key_click
);

    logic is_digit;
    logic is_cancel;
    logic room;

    assign is_digit  = key_strobe && (key_code < lock_pkg::KEY_ENTER);   // codes below enter
    assign is_cancel = key_strobe && (key_code == lock_pkg::KEY_CANCEL);
    assign room      = (digit_count < 2'(lock_pkg::CODE_LEN));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entry.raw   <= lock_pkg::GLYPH_BLANK;
            digit_count <= 2'd0;
            enter_req   <= 1'b0;
            cancel_req  <= 1'b0;
            admin_req   <= 1'b0;
            key_click   <= 1'b0;
        end else begin
            // commands pass through even while locked
            enter_req  <= key_strobe && (key_code == lock_pkg::KEY_ENTER);
            cancel_req <= is_cancel;
            admin_req  <= key_strobe && (key_code == lock_pkg::KEY_ADMIN);
            key_click  <= 1'b0;

            if (clear_entry || is_cancel) begin
                entry.raw   <= lock_pkg::GLYPH_BLANK;
                digit_count <= 2'd0;
            end else if (is_digit && !locked && room) begin
                entry.digit <= {entry.digit[1:0], key_code};   // newest into low nibble
                digit_count <= digit_count + 2'd1;
                key_click   <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/code_checker.sv ====
module code_checker (
    input  logic                       clk,
    input  logic                       arst_n,
    input  lock_pkg::display_t         entry,
    input  logic [1:0]                 digit_count,
    input  logic                       enter_req,
    input  logic                       cancel_req,
    input  logic                       admin_req,
    output logic                       clear_entry,
    output logic                       locked,
    output logic                       unlocked,
    output logic [lock_pkg::TRY_W-1:0] tries,
    output lock_pkg::display_t         display,
    output logic                       pass_evt,
    output logic                       fail_evt
);

    logic                       attempt;
    logic [lock_pkg::TRY_W-1:0] tries_nxt;
    logic                       locked_nxt;
    logic                       unlocked_nxt;
    logic                       pass_nxt;
    logic                       fail_nxt;
    lock_pkg::display_t         display_nxt;

    // short entries are ignored
    assign attempt = enter_req && (digit_count == 2'(lock_pkg::CODE_LEN)) && !locked;

    always_comb begin
        tries_nxt    = tries;
        locked_nxt   = locked;
        unlocked_nxt = unlocked;
        pass_nxt     = 1'b0;
        fail_nxt     = 1'b0;

        if (admin_req) begin
            tries_nxt    = '0;
            locked_nxt   = 1'b0;
            unlocked_nxt = 1'b0;
        end else if (cancel_req) begin
            unlocked_nxt = 1'b0;
        end else if (attempt) begin
            if (entry == lock_pkg::SECRET_CODE) begin
                unlocked_nxt = 1'b1;
                pass_nxt     = 1'b1;
            end else begin
                tries_nxt = tries + 1'b1;
                fail_nxt  = 1'b1;
                if (tries_nxt == lock_pkg::TRY_W'(lock_pkg::MAX_TRIES)) begin
                    locked_nxt = 1'b1;
                end
            end
        end

        // blank while the entry clear is still on its way back
        if (locked_nxt) begin
            display_nxt.raw = lock_pkg::GLYPH_LOCKED;
        end else if (unlocked_nxt) begin
            display_nxt.raw = lock_pkg::GLYPH_PASS;
        end else if (fail_nxt || clear_entry) begin
            display_nxt.raw = lock_pkg::GLYPH_BLANK;
        end else begin
            display_nxt = entry;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tries       <= '0;
            locked      <= 1'b0;
            unlocked    <= 1'b0;
            pass_evt    <= 1'b0;
            fail_evt    <= 1'b0;
            clear_entry <= 1'b0;
            display.raw <= lock_pkg::GLYPH_BLANK;
        end else begin
            tries       <= tries_nxt;
            locked      <= locked_nxt;
            unlocked    <= unlocked_nxt;
            pass_evt    <= pass_nxt;
            fail_evt    <= fail_nxt;
            clear_entry <= fail_nxt;               // wrong code empties the entry
            display     <= display_nxt;
        end
    end

endmodule

// ==== hdl/buzzer_sequencer.sv ====
module buzzer_sequencer (
    input  logic clk,
    input  logic arst_n,
    input  logic key_click,
    input  logic pass_evt,
    input  logic fail_evt,
    output logic buzzer
);

    logic [lock_pkg::PAT_W-1:0]  pattern;
    logic [lock_pkg::PAT_W-1:0]  start_pat;
    logic [lock_pkg::DUR_W-1:0]  dur_cnt;
    logic [lock_pkg::DUR_W-1:0]  dur_nxt;
    logic [lock_pkg::DUR_W-1:0]  dur_lim;
    logic [lock_pkg::HALF_W-1:0] half_cnt;
    logic [lock_pkg::HALF_W-1:0] half_lim;
    logic                        in_gap;

    // pass beats fail beats click
    always_comb begin
        if (pass_evt) begin
            start_pat = lock_pkg::PAT_PASS;
        end else if (fail_evt) begin
            start_pat = lock_pkg::PAT_FAIL;
        end else if (key_click) begin
            start_pat = lock_pkg::PAT_CLICK;
        end else begin
            start_pat = lock_pkg::PAT_IDLE;
        end
    end

    // limits of the running pattern
    always_comb begin
        case (pattern)
            lock_pkg::PAT_CLICK: begin
                dur_lim  = lock_pkg::DUR_W'(lock_pkg::CLICK_CYCLES - 1);
                half_lim = lock_pkg::HALF_W'(lock_pkg::CLICK_HALF - 1);
            end
            lock_pkg::PAT_PASS: begin
                dur_lim  = lock_pkg::DUR_W'(lock_pkg::PASS_CYCLES - 1);
                half_lim = lock_pkg::HALF_W'(lock_pkg::PASS_HALF - 1);
            end
            lock_pkg::PAT_FAIL: begin
                dur_lim  = lock_pkg::DUR_W'(lock_pkg::FAIL_CYCLES - 1);
                half_lim = lock_pkg::HALF_W'(lock_pkg::FAIL_HALF - 1);
            end
            default: begin
                dur_lim  = '0;
                half_lim = '0;
            end
        endcase
    end

    assign dur_nxt = dur_cnt + 1'b1;
    assign in_gap  = (pattern == lock_pkg::PAT_FAIL)
                  && (dur_nxt >= lock_pkg::DUR_W'(lock_pkg::FAIL_GAP_LO))
                  && (dur_nxt <  lock_pkg::DUR_W'(lock_pkg::FAIL_GAP_HI));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pattern  <= lock_pkg::PAT_IDLE;
            dur_cnt  <= '0;
            half_cnt <= '0;
            buzzer   <= 1'b0;
        end else if (start_pat != lock_pkg::PAT_IDLE) begin
            pattern  <= start_pat;                 // restart on any new event
            dur_cnt  <= '0;
            half_cnt <= '0;
            buzzer   <= 1'b1;
        end else if (pattern != lock_pkg::PAT_IDLE) begin
            if (dur_cnt == dur_lim) begin
                pattern  <= lock_pkg::PAT_IDLE;    // pattern done
                dur_cnt  <= '0;
                half_cnt <= '0;
                buzzer   <= 1'b0;
            end else begin
                dur_cnt <= dur_nxt;
                if (half_cnt == half_lim) begin
                    half_cnt <= '0;
                    buzzer   <= ~buzzer;
                end else begin
                    half_cnt <= half_cnt + 1'b1;
                end
                if (in_gap) begin
                    buzzer <= 1'b0;                // tone keeps its phase through the gap
                end
            end
        end
    end

endmodule

// ==== hdl/code_lock_top.sv ====
module code_lock_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [15:0]                onehot,
    output lock_pkg::display_t         display,
    output logic [lock_pkg::TRY_W-1:0] tries,
    output logic                       locked,
    output logic                       unlocked,
    output logic                       buzzer
);

    logic               key_strobe;
    lock_pkg::key_t     key_code;
    lock_pkg::display_t entry;
    logic [1:0]         digit_count;
    logic               enter_req;
    logic               cancel_req;
    logic               admin_req;
    logic               key_click;
    logic               clear_entry;
    logic               pass_evt;
    logic               fail_evt;

    key_decoder key_decoder_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .onehot     (onehot),
        .key_strobe (key_strobe),
        .key_code   (key_code)
    );

    code_entry code_entry_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .key_strobe  (key_strobe),
        .key_code    (key_code),
        .locked      (locked),                     // fed back from the checker
        .clear_entry (clear_entry),
        .entry       (entry),
        .digit_count (digit_count),
        .enter_req   (enter_req),
        .cancel_req  (cancel_req),
        .admin_req   (admin_req),
        .key_click   (key_click)
    );

    code_checker code_checker_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .entry       (entry),
        .digit_count (digit_count),
        .enter_req   (enter_req),
        .cancel_req  (cancel_req),
        .admin_req   (admin_req),
        .clear_entry (clear_entry),
        .locked      (locked),
        .unlocked    (unlocked),
        .tries       (tries),
        .display     (display),
        .pass_evt    (pass_evt),
        .fail_evt    (fail_evt)
    );

    buzzer_sequencer buzzer_sequencer_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .key_click (key_click),
        .pass_evt  (pass_evt),
        .fail_evt  (fail_evt),
        .buzzer    (buzzer)
    );

endmodule

// ==== sim/code_lock_tb.sv ====
module code_lock_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD    = 10;
    localparam int NUM_OPS       = 300;
    localparam int MAX_OP_CYCLES = 15;             // longest hold plus longest release
    localparam logic [11:0] SECRET_RAW = 12'h246;  // digits 2 4 6 with the newest lowest
    localparam int WATCHDOG_NS = ((NUM_OPS * 4 + 40) * MAX_OP_CYCLES
                                 + lock_pkg::CLICK_CYCLES + lock_pkg::FAIL_CYCLES
                                 + lock_pkg::PASS_CYCLES) * CLK_PERIOD * 2;

    logic                       clk;
    logic                       arst_n;
    logic [15:0]                onehot;
    lock_pkg::display_t         display;
    logic [lock_pkg::TRY_W-1:0] tries;
    logic                       locked;
    logic                       unlocked;
    logic                       buzzer;

    logic [15:0] lfsr_state;
    logic [11:0] m_entry;                          // reference model state
    int          m_count;
    int          m_tries;
    logic        m_locked;
    logic        m_unlocked;

    code_lock_top code_lock_top_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .onehot   (onehot),
        .display  (display),
        .tries    (tries),
        .locked   (locked),
        .unlocked (unlocked),
        .buzzer   (buzzer)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "run stopped at first error");
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int take_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);    // one step per bit
            val = (val << 1) | lfsr_state[0];
        end
        return val;
    endfunction

    function automatic logic [15:0] line_for_key(input lock_pkg::key_t k);
        logic [15:0] line;
        line = '0;
        for (int i = 0; i < 16; i++) begin
            if (lock_pkg::KEYMAP[i] == k) begin
                line = 16'd1 << i;
            end
        end
        return line;
    endfunction

    task automatic apply_model(input lock_pkg::key_t k, output logic click);
        click = 1'b0;
        if (k <= 4'd9) begin
            if (!m_locked && m_count < lock_pkg::CODE_LEN) begin
                m_entry = {m_entry[7:0], k};
                m_count++;
                click = 1'b1;
            end
        end else if (k == lock_pkg::KEY_ENTER) begin
            if (m_count == lock_pkg::CODE_LEN && !m_locked) begin
                if (m_entry == SECRET_RAW) begin
                    m_unlocked = 1'b1;
                end else begin
                    m_tries++;
                    m_entry = lock_pkg::GLYPH_BLANK;
                    m_count = 0;
                    m_locked = (m_tries == lock_pkg::MAX_TRIES);
                end
            end
        end else if (k == lock_pkg::KEY_CANCEL) begin
            m_entry    = lock_pkg::GLYPH_BLANK;
            m_count    = 0;
            m_unlocked = 1'b0;
        end else if (k == lock_pkg::KEY_ADMIN) begin
            m_tries    = 0;
            m_locked   = 1'b0;
            m_unlocked = 1'b0;
        end
    endtask

    task automatic check_model(input string where);
        logic [11:0] exp_disp;
        exp_disp = m_locked ? lock_pkg::GLYPH_LOCKED
                 : (m_unlocked ? lock_pkg::GLYPH_PASS : m_entry);
        assert (display.raw == exp_disp) else abort_run($sformatf(
            "FAIL %0t ns: %s, display %h, expected %h", $time, where, display.raw, exp_disp));
        assert (int'(tries) == m_tries) else abort_run($sformatf(
            "FAIL %0t ns: %s, tries %0d, expected %0d", $time, where, tries, m_tries));
        assert (locked == m_locked && unlocked == m_unlocked) else abort_run($sformatf(
            "FAIL %0t ns: %s, locked/unlocked %b%b, expected %b%b", $time, where,
            locked, unlocked, m_locked, m_unlocked));
    endtask

    // press, hold, release, then compare once the pipeline has settled
    task automatic do_key(input lock_pkg::key_t k, input int hold, input int rel);
        logic click;
        apply_model(k, click);
        onehot = line_for_key(k);
        for (int m = 1; m <= hold; m++) begin
            @(posedge clk);
            #1;
            if (m == 4 && click) begin             // one cycle after key_click
                assert (buzzer == 1'b1) else abort_run($sformatf(
                    "FAIL %0t ns: no click tone after digit %0d", $time, k));
            end
        end
        onehot = '0;
        repeat (rel) begin
            @(posedge clk);
            #1;
        end
        check_model($sformatf("after key %0d", k));
    endtask

    task automatic check_click_tone(input lock_pkg::key_t k);
        int   toggles;
        logic last;
        toggles = 0;
        do_key(k, 4, 5);
        last = buzzer;
        repeat (lock_pkg::CLICK_CYCLES) begin
            @(posedge clk);
            #1;
            if (buzzer != last) begin
                toggles++;
            end
            last = buzzer;
        end
        assert (toggles >= lock_pkg::CLICK_CYCLES / lock_pkg::CLICK_HALF / 2) else abort_run(
            $sformatf("FAIL %0t ns: click tone toggled only %0d times", $time, toggles));
        assert (buzzer == 1'b0) else abort_run(
            $sformatf("FAIL %0t ns: buzzer still on after click pattern", $time));
    endtask

    // enter a wrong code and watch the whole failure pattern
    task automatic check_fail_tone();
        logic click;
        int   gap_lo;
        int   gap_hi;
        gap_lo = 5 + lock_pkg::FAIL_GAP_LO + 1;    // pattern starts 5 cycles after press
        gap_hi = 5 + lock_pkg::FAIL_GAP_HI - 2;
        apply_model(lock_pkg::KEY_ENTER, click);
        onehot = line_for_key(lock_pkg::KEY_ENTER);
        for (int m = 1; m <= lock_pkg::FAIL_CYCLES + 10; m++) begin
            @(posedge clk);
            #1;
            if (m == 4) begin
                onehot = '0;
            end
            if (m == 5 || (m >= gap_lo && m <= gap_hi)) begin
                assert (buzzer == (m == 5)) else abort_run($sformatf(
                    "FAIL %0t ns: buzzer %b at cycle %0d of fail tone", $time, buzzer, m));
            end
        end
        assert (buzzer == 1'b0) else abort_run(
            $sformatf("FAIL %0t ns: buzzer still on after fail pattern", $time));
        check_model("after fail tone");
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("watchdog expired at %0t ns, the run did not finish", $time));
    end

    initial begin
        int sel;
        int hold;
        int rel;
        $timeformat(-9, 0, "", 0);                 // times in whole ns
        clk        = 1'b0;
        arst_n     = 1'b0;
        onehot     = '0;
        lfsr_state = 16'd51;
        m_entry    = lock_pkg::GLYPH_BLANK;
        m_count    = 0;
        m_tries    = 0;
        m_locked   = 1'b0;
        m_unlocked = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        assert (buzzer == 1'b0) else abort_run(
            $sformatf("FAIL %0t ns: buzzer on after reset", $time));
        check_model("after reset");

        // fourth digit is dropped
        do_key(4'd1, 4, 5);
        do_key(4'd3, 4, 5);
        do_key(4'd5, 4, 5);
        do_key(4'd7, 4, 5);
        assert (display.digit[0] == 4'd5 && display.digit[2] == 4'd1) else abort_run(
            $sformatf("FAIL %0t ns: digit nibbles in wrong order, %h", $time, display.raw));
        do_key(lock_pkg::KEY_CANCEL, 4, 5);

        do_key(4'd2, 4, 5);
        do_key(4'd4, 4, 5);
        do_key(4'd6, 4, 5);
        do_key(lock_pkg::KEY_ENTER, 4, 5);
        assert (unlocked && display.raw == lock_pkg::GLYPH_PASS) else abort_run(
            $sformatf("FAIL %0t ns: correct code did not open the lock", $time));
        do_key(lock_pkg::KEY_CANCEL, 4, 5);

        // wrong codes until lockout and one short entry in between
        for (int a = 0; a < lock_pkg::MAX_TRIES; a++) begin
            do_key(4'd9, 4, 5);
            do_key(4'd9, 4, 5);
            do_key(4'd9, 4, 5);
            do_key(lock_pkg::KEY_ENTER, 4, 5);
            if (a == 0) begin
                do_key(4'd1, 4, 5);
                do_key(lock_pkg::KEY_ENTER, 4, 5);
                do_key(lock_pkg::KEY_CANCEL, 4, 5);
            end
        end
        assert (locked && display.raw == lock_pkg::GLYPH_LOCKED) else abort_run(
            $sformatf("FAIL %0t ns: no lockout after %0d failures", $time, lock_pkg::MAX_TRIES));
        do_key(4'd2, 4, 5);                        // ignored while locked
        do_key(lock_pkg::KEY_ADMIN, 4, 5);

        check_click_tone(4'd1);
        do_key(4'd8, 4, 5);
        do_key(4'd8, 4, 5);
        check_fail_tone();

        for (int op = 0; op < NUM_OPS; op++) begin
            sel  = take_bits(4);
            hold = 4 + take_bits(2);
            rel  = 5 + take_bits(2);
            if (sel < 7) begin
                do_key(lock_pkg::key_t'(take_bits(4) % 10), hold, rel);
            end else if (sel < 10) begin
                do_key(lock_pkg::KEY_ENTER, hold, rel);
            end else if (sel < 12) begin
                do_key(lock_pkg::KEY_CANCEL, hold, rel);
            end else if (sel == 12) begin
                do_key(lock_pkg::KEY_ADMIN, hold, rel);
            end else begin
                do_key(4'd2, hold, rel);           // correct code burst
                do_key(4'd4, hold, rel);
                do_key(4'd6, hold, rel);
                do_key(lock_pkg::KEY_ENTER, hold, rel);
            end
        end

        $display("test passed");
        $finish;
    end

endmodule

// ==== tb.f ====
hdl/lock_pkg.sv
hdl/key_decoder.sv
hdl/code_entry.sv
hdl/code_checker.sv
hdl/buzzer_sequencer.sv
hdl/code_lock_top.sv
sim/code_lock_tb.sv
